// File: zxclk.f
zxclk_pkg.sv
pll_reconf_sequencer.sv
drp_cmd_fifo.sv
pll_divider_bank.sv
cpu_clock_select.sv
clock_generator.sv
tb_clock_generator.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the zxclk testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f zxclk.f --top-module tb_clock_generator \
  -o tb_clock_generator > sim.log 2>&1 &&
  ./obj_dir/tb_clock_generator >> sim.log 2>&1 ||
  echo "Build or run did not complete" >> sim.log
cat sim.log
# A fail message, or no pass message at all, means failure
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0

// File: tb_clock_generator.sv
`default_nettype none

module tb_clock_generator
  import zxclk_pkg::*;
();

  localparam int fifo_depth  = 4;
  localparam int lock_cycles = 20;
  localparam int wait_limit  = 400;

  // Reference base dividers, one per option
  localparam int model_base [8] = '{2, 3, 4, 5, 6, 7, 8, 9};

  // Multiplier on the base for out1..out4
  localparam int out_mult [4] = '{1, 2, 4, 8};

  logic                    clkin1_buffered;
  logic                    arst_n;
  logic [option_width-1:0] pll_option;
  logic [1:0]              turbo_enable;
  logic                    cpu_contention;
  logic                    clk_en_out1;
  logic                    clk_en_out2;
  logic                    clk_en_out3;
  logic                    clk_en_out4;
  logic                    cpu_clk_en;
  logic                    cpu_clk_en_plain;
  logic                    srdy;
  logic                    locked;

  logic [15:0]             lfsr;
  logic [option_width-1:0] cur_option;
  int                      cyc;
  int                      checks;
  int                      errors;

  clock_generator #(
    .fifo_depth  (fifo_depth),
    .lock_cycles (lock_cycles)
  ) i_dut (
    .clkin1_buffered  (clkin1_buffered),
    .arst_n           (arst_n),
    .pll_option       (pll_option),
    .turbo_enable     (turbo_enable),
    .cpu_contention   (cpu_contention),
    .clk_en_out1      (clk_en_out1),
    .clk_en_out2      (clk_en_out2),
    .clk_en_out3      (clk_en_out3),
    .clk_en_out4      (clk_en_out4),
    .cpu_clk_en       (cpu_clk_en),
    .cpu_clk_en_plain (cpu_clk_en_plain),
    .srdy             (srdy),
    .locked           (locked)
  );

  always #5 clkin1_buffered = !clkin1_buffered;

  // Galois LFSR, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[6:0], lfsr[0]};
    end
  endtask

  // Outputs sampled and inputs driven 1 unit after the edge
  task automatic step();
    @(posedge clkin1_buffered);
    #1;
    cyc++;
  endtask

  // 0..3 are out1..out4
  function automatic logic strobe_of(input int sel);
    case (sel)
      0:       return clk_en_out1;
      1:       return clk_en_out2;
      2:       return clk_en_out3;
      default: return clk_en_out4;
    endcase
  endfunction

  // Turbo map: 00 is 8x base, 01 is 4x, 1x is 2x
  function automatic int turbo_period(input logic [1:0] t, input int base);
    if (t[1]) begin
      return base * 2;
    end
    return t[0] ? base * 4 : base * 8;
  endfunction

  task automatic check_period(input string name, input logic [div_width-1:0] exp,
                              input logic [div_width-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_sel_period(input string name, input logic [div_width-1:0] exp,
                                  input logic [div_width-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_locked(input string name, input bit exp, input bit act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected locked %0b actual %0b", name, exp, act);
    end
  endtask

  task automatic check_strobe(input string name, input bit exp, input bit act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s expected %0b actual %0b", name, exp, act);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
  endtask

  task automatic end_test(input string name, input int start_errors);
    $display("test %s finished with %0d errors", name, errors - start_errors);
  endtask

  task automatic wait_for_srdy(input string name);
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (srdy !== 1'b1 && n < wait_limit);
    if (srdy !== 1'b1) begin
      report_timeout($sformatf("srdy in %s", name));
    end else begin
      check_locked(name, 1'b1, locked);
    end
  endtask

  task automatic wait_for_unlock(input string name);
    int n;
    n = 0;
    do begin
      step();
      n++;
    end while (locked !== 1'b0 && n < wait_limit);
    if (locked !== 1'b0) begin
      report_timeout($sformatf("locked to fall in %s", name));
    end
  endtask

  // Cycles between two strobes of one source
  task automatic measure_period(input int sel, output int per);
    int n;
    per = 0;
    n = 0;
    do begin
      step();
      n++;
    end while (strobe_of(sel) !== 1'b1 && n < wait_limit);
    if (strobe_of(sel) !== 1'b1) begin
      report_timeout($sformatf("first strobe of source %0d", sel));
      return;
    end
    n = 0;
    do begin
      step();
      n++;
    end while (strobe_of(sel) !== 1'b1 && n < wait_limit);
    if (strobe_of(sel) !== 1'b1) begin
      report_timeout($sformatf("second strobe of source %0d", sel));
    end else begin
      per = n;
    end
  endtask

  // Output n divides by base times its multiplier
  task automatic check_outputs(input string name, input int base);
    int per;
    for (int ch = 0; ch < 4; ch++) begin
      measure_period(ch, per);
      check_period($sformatf("%s out%0d", name, ch + 1), div_width'(base * out_mult[ch]),
                   div_width'(per));
    end
  endtask

  // Random option that differs from the one given
  task automatic pick_option(input logic [option_width-1:0] avoid,
                             output logic [option_width-1:0] opt);
    logic [7:0] r;
    take_bits(option_width, r);
    opt = r[option_width-1:0];
    if (opt == avoid) begin
      opt = opt + 1'b1;
    end
  endtask

  task automatic test_boot();
    int start_err;
    start_err = errors;
    wait_for_srdy("boot");
    // Ready strobe is a single cycle
    step();
    check_strobe("boot srdy width", 1'b0, srdy);
    check_outputs("boot", model_base[0]);
    end_test("boot", start_err);
  endtask

  task automatic test_random_options();
    int                      start_err;
    logic [option_width-1:0] opt;
    string                   name;
    start_err = errors;
    for (int k = 0; k < 8; k++) begin
      pick_option(cur_option, opt);
      name       = $sformatf("option %0d", opt);
      pll_option = opt;
      cur_option = opt;
      wait_for_unlock(name);
      wait_for_srdy(name);
      check_outputs(name, model_base[opt]);
    end
    end_test("random options", start_err);
  endtask

  task automatic test_back_to_back();
    int                      start_err;
    logic [option_width-1:0] opt_a;
    logic [option_width-1:0] opt_b;
    start_err = errors;
    pick_option(cur_option, opt_a);
    pick_option(opt_a, opt_b);
    pll_option = opt_a;
    repeat (3) step();
    pll_option = opt_b;
    cur_option = opt_b;
    wait_for_srdy("back to back");
    check_outputs($sformatf("back to back option %0d", opt_b), model_base[opt_b]);
    end_test("back to back", start_err);
  endtask

  task automatic test_turbo();
    int         start_err;
    int         n;
    int         seen;
    int         last_cyc;
    int         interval;
    int         old_per;
    int         new_per;
    int         min_per;
    int         base;
    logic [7:0] r;
    string      name;
    start_err = errors;
    base      = model_base[cur_option];
    old_per   = turbo_period(turbo_enable, base);
    n = 0;
    do begin
      step();
      n++;
    end while (cpu_clk_en_plain !== 1'b1 && n < wait_limit);
    if (cpu_clk_en_plain !== 1'b1) begin
      report_timeout("a CPU strobe before turbo changes");
    end
    last_cyc = cyc;
    for (int k = 0; k < 6; k++) begin
      take_bits(2, r);
      turbo_enable = r[1:0];
      new_per      = turbo_period(r[1:0], base);
      min_per      = (new_per < old_per) ? new_per : old_per;
      name         = $sformatf("turbo %0d", r[1:0]);
      seen = 0;
      n    = 0;
      while (seen < 3 && n < wait_limit) begin
        step();
        n++;
        if (cpu_clk_en_plain === 1'b1) begin
          interval = cyc - last_cyc;
          last_cyc = cyc;
          seen++;
          if (seen == 1) begin
            // Old source stays in use up to its own next strobe
            check_sel_period({name, " hold"}, div_width'(old_per), div_width'(interval));
          end else if (seen == 2) begin
            checks++;
            if (interval < min_per) begin
              errors++;
              $display("ERR %s expected at least %0d actual %0d", name, min_per, interval);
            end
          end else begin
            // Third strobe after the change is a full new period
            check_sel_period(name, div_width'(new_per), div_width'(interval));
          end
        end
      end
      if (seen < 3) begin
        report_timeout($sformatf("CPU strobes after %s", name));
      end
      old_per = new_per;
    end
    end_test("turbo", start_err);
  endtask

  task automatic test_contention();
    int         start_err;
    int         window;
    logic       prev_cont;
    logic [7:0] r;
    start_err    = errors;
    // Fastest source for many strobes
    turbo_enable = 2'b10;
    prev_cont    = cpu_contention;
    window       = 0;
    for (int i = 0; i < 300; i++) begin
      step();
      if (prev_cont) begin
        check_strobe("contention hold", 1'b0, cpu_clk_en);
      end else begin
        check_strobe("contention free", cpu_clk_en_plain, cpu_clk_en);
      end
      // Random high or low window of 1 to 8 cycles
      if (window == 0) begin
        take_bits(1, r);
        cpu_contention = r[0];
        take_bits(3, r);
        window = int'(r[2:0]) + 1;
      end
      window--;
      prev_cont = cpu_contention;
    end
    cpu_contention = 1'b0;
    end_test("contention", start_err);
  endtask

  initial begin
    clkin1_buffered = 1'b0;
    arst_n          = 1'b0;
    pll_option      = '0;
    turbo_enable    = 2'b00;
    cpu_contention  = 1'b0;
    lfsr            = 16'd48;
    cur_option      = '0;
    cyc             = 0;
    checks          = 0;
    errors          = 0;
    repeat (16) @(posedge clkin1_buffered);
    #1;
    arst_n = 1'b1;
    test_boot();
    test_random_options();
    test_back_to_back();
    test_turbo();
    test_contention();
    $display("Totals: 5 tests, %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: clock_generator.sv
`default_nettype none

module clock_generator
  import zxclk_pkg::*;
#(
  parameter int fifo_depth  = 4,
  parameter int lock_cycles = 20
) (
  input  wire logic                    clkin1_buffered,
  input  wire logic                    arst_n,
  input  wire logic [option_width-1:0] pll_option,
  input  wire logic [1:0]              turbo_enable,
  input  wire logic                    cpu_contention,
  output wire logic                    clk_en_out1,
  output wire logic                    clk_en_out2,
  output wire logic                    clk_en_out3,
  output wire logic                    clk_en_out4,
  output wire logic                    cpu_clk_en,
  output wire logic                    cpu_clk_en_plain,
  output wire logic                    srdy,
  output wire logic                    locked
);

  // Sequencer to FIFO
  logic                 wr_en;
  drp_op_e              wr_op;
  logic [1:0]           wr_addr;
  logic [div_width-1:0] wr_data;
  logic                 full;

  // FIFO to divider bank
  logic                 rd_en;
  drp_op_e              rd_op;
  logic [1:0]           rd_addr;
  logic [div_width-1:0] rd_data;
  logic                 empty;

  pll_reconf_sequencer i_sequencer (
    .clkin1_buffered (clkin1_buffered),
    .arst_n          (arst_n),
    .pll_option      (pll_option),
    .full            (full),
    .wr_en           (wr_en),
    .wr_op           (wr_op),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data)
  );

  drp_cmd_fifo #(
    .fifo_depth (fifo_depth)
  ) i_cmd_fifo (
    .clkin1_buffered (clkin1_buffered),
    .arst_n          (arst_n),
    .wr_en           (wr_en),
    .wr_op           (wr_op),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .full            (full),
    .empty           (empty),
    .rd_op           (rd_op),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  pll_divider_bank #(
    .lock_cycles (lock_cycles)
  ) i_divider_bank (
    .clkin1_buffered (clkin1_buffered),
    .arst_n          (arst_n),
    .empty           (empty),
    .rd_op           (rd_op),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .rd_en           (rd_en),
    .srdy            (srdy),
    .locked          (locked),
    .clk_en_out1     (clk_en_out1),
    .clk_en_out2     (clk_en_out2),
    .clk_en_out3     (clk_en_out3),
    .clk_en_out4     (clk_en_out4)
  );

  // CPU strobe from the three slower outputs
  cpu_clock_select i_cpu_select (
    .clkin1_buffered  (clkin1_buffered),
    .arst_n           (arst_n),
    .turbo_enable     (turbo_enable),
    .cpu_contention   (cpu_contention),
    .clk_en_out2      (clk_en_out2),
    .clk_en_out3      (clk_en_out3),
    .clk_en_out4      (clk_en_out4),
    .cpu_clk_en       (cpu_clk_en),
    .cpu_clk_en_plain (cpu_clk_en_plain)
  );

endmodule

`default_nettype wire

// File: cpu_clock_select.sv
`default_nettype none

module cpu_clock_select (
  input  wire logic       clkin1_buffered,
  input  wire logic       arst_n,
  input  wire logic [1:0] turbo_enable,
  input  wire logic       cpu_contention,
  input  wire logic       clk_en_out2,
  input  wire logic       clk_en_out3,
  input  wire logic       clk_en_out4,
  output logic            cpu_clk_en,
  output logic            cpu_clk_en_plain
);

  logic [1:0] req_sel;
  logic [1:0] act_sel;
  logic       act_valid;
  logic       act_strobe;

  // Source codes
  // 0 is out4, 1 is out3, 2 is out2
  assign req_sel = turbo_enable[1] ? 2'd2 : {1'b0, turbo_enable[0]};

  // Strobe of the source in use
  always_comb begin
    case (act_sel)
      2'd0:    act_strobe = clk_en_out4;
      2'd1:    act_strobe = clk_en_out3;
      default: act_strobe = clk_en_out2;
    endcase
  end

  always_ff @(posedge clkin1_buffered or negedge arst_n) begin
    if (!arst_n) begin
      act_sel          <= 2'd0;
      act_valid        <= 1'b0;
      cpu_clk_en_plain <= 1'b0;
      cpu_clk_en       <= 1'b0;
    end else begin
      // Swap only on an old-source strobe, so no short period
      if (!act_valid || act_strobe) begin
        act_sel   <= req_sel;
        act_valid <= 1'b1;
      end
      cpu_clk_en_plain <= act_valid && act_strobe;
      // Contention holds the CPU
      cpu_clk_en       <= act_valid && act_strobe && !cpu_contention;
    end
  end

endmodule

`default_nettype wire

// File: pll_divider_bank.sv
`default_nettype none

module pll_divider_bank
  import zxclk_pkg::*;
#(
  parameter int lock_cycles = 20
) (
  input  wire logic                 clkin1_buffered,
  input  wire logic                 arst_n,
  input  wire logic                 empty,
  input  wire drp_op_e              rd_op,
  input  wire logic [1:0]           rd_addr,
  input  wire logic [div_width-1:0] rd_data,
  output logic                      rd_en,
  output logic                      srdy,
  output logic                      locked,
  output logic                      clk_en_out1,
  output logic                      clk_en_out2,
  output logic                      clk_en_out3,
  output logic                      clk_en_out4
);

  localparam int lock_width = $clog2(lock_cycles + 1);
  localparam logic [lock_width-1:0] lock_last = lock_width'(lock_cycles - 1);

  logic [3:0][div_width-1:0] div_reg;
  logic [3:0]                strobe;
  logic [lock_width-1:0]     lock_cnt;
  logic                      lock_busy;
  logic                      write_pop;
  logic                      done_pop;
  logic                      lock_end;
  logic                      run;

  // No pops while lock time runs, this is the back-pressure
  assign rd_en     = !empty && !lock_busy;
  assign write_pop = rd_en && (rd_op == drp_write);
  assign done_pop  = rd_en && (rd_op == drp_done);
  assign lock_end  = lock_busy && (lock_cnt == lock_last);
  // Counters run only while locked and no write is landing
  assign run       = locked && !write_pop;

  // Divider values
  always_ff @(posedge clkin1_buffered) begin
    if (write_pop) begin
      div_reg[rd_addr] <= rd_data;
    end
  end

  // Lock timing and ready strobe
  always_ff @(posedge clkin1_buffered or negedge arst_n) begin
    if (!arst_n) begin
      lock_busy <= 1'b0;
      lock_cnt  <= '0;
      locked    <= 1'b0;
      srdy      <= 1'b0;
    end else begin
      srdy <= lock_end;
      if (write_pop) begin
        locked <= 1'b0;
      end else if (lock_end) begin
        locked <= 1'b1;
      end
      if (done_pop) begin
        lock_busy <= 1'b1;
        lock_cnt  <= '0;
      end else if (lock_end) begin
        lock_busy <= 1'b0;
      end else if (lock_busy) begin
        lock_cnt <= lock_cnt + 1'b1;
      end
    end
  end

  // One down-counter per output
  for (genvar ch = 0; ch < 4; ch++) begin : g_channel
    logic [div_width-1:0] cnt;
    logic                 tick;

    always_ff @(posedge clkin1_buffered or negedge arst_n) begin
      if (!arst_n) begin
        cnt  <= '0;
        tick <= 1'b0;
      end else if (lock_end) begin
        // All channels restart together, first tick one cycle after srdy
        cnt  <= '0;
        tick <= 1'b0;
      end else if (!run) begin
        tick <= 1'b0;
      end else if (cnt == '0) begin
        tick <= 1'b1;
        cnt  <= div_reg[ch] - 1'b1;
      end else begin
        tick <= 1'b0;
        cnt  <= cnt - 1'b1;
      end
    end

    assign strobe[ch] = tick;
  end

  assign clk_en_out1 = strobe[0];
  assign clk_en_out2 = strobe[1];
  assign clk_en_out3 = strobe[2];
  assign clk_en_out4 = strobe[3];

  a_srdy_single: assert property (
    @(posedge clkin1_buffered) disable iff (!arst_n)
    srdy |=> !srdy
  );

  a_no_enable_unlocked: assert property (
    @(posedge clkin1_buffered) disable iff (!arst_n)
    !locked |-> (strobe == 4'b0000)
  );

endmodule

`default_nettype wire

// File: drp_cmd_fifo.sv
`default_nettype none

module drp_cmd_fifo
  import zxclk_pkg::*;
#(
  parameter int fifo_depth = 4
) (
  input  wire logic                 clkin1_buffered,
  input  wire logic                 arst_n,
  input  wire logic                 wr_en,
  input  wire drp_op_e              wr_op,
  input  wire logic [1:0]           wr_addr,
  input  wire logic [div_width-1:0] wr_data,
  input  wire logic                 rd_en,
  output logic                      full,
  output logic                      empty,
  output drp_op_e                   rd_op,
  output logic [1:0]                rd_addr,
  output logic [div_width-1:0]      rd_data
);

  localparam int ptr_width = $clog2(fifo_depth);
  localparam logic [ptr_width:0] count_max = (ptr_width + 1)'(fifo_depth);

  // Command storage split per field
  drp_op_e              op_mem   [fifo_depth];
  logic [1:0]           addr_mem [fifo_depth];
  logic [div_width-1:0] data_mem [fifo_depth];

  logic [ptr_width-1:0] wr_ptr;
  logic [ptr_width-1:0] rd_ptr;
  logic [ptr_width:0]   count;
  logic                 push;
  logic                 pop;

  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  // Level flags straight from occupancy
  assign full  = (count == count_max);
  assign empty = (count == '0);

  // Head word always visible
  assign rd_op   = op_mem[rd_ptr];
  assign rd_addr = addr_mem[rd_ptr];
  assign rd_data = data_mem[rd_ptr];

  always_ff @(posedge clkin1_buffered) begin
    if (push) begin
      op_mem[wr_ptr]   <= wr_op;
      addr_mem[wr_ptr] <= wr_addr;
      data_mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap on power-of-two depth
  always_ff @(posedge clkin1_buffered or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_write_full: assert property (
    @(posedge clkin1_buffered) disable iff (!arst_n)
    wr_en |-> !full
  );

  a_no_read_empty: assert property (
    @(posedge clkin1_buffered) disable iff (!arst_n)
    rd_en |-> !empty
  );

endmodule

`default_nettype wire

// File: pll_reconf_sequencer.sv
`default_nettype none

module pll_reconf_sequencer
  import zxclk_pkg::*;
(
  input  wire logic                    clkin1_buffered,
  input  wire logic                    arst_n,
  input  wire logic [option_width-1:0] pll_option,
  input  wire logic                    full,
  output logic                         wr_en,
  output drp_op_e                      wr_op,
  output logic [1:0]                   wr_addr,
  output logic [div_width-1:0]         wr_data
);

  logic [option_width-1:0] option_stored;
  logic [7:0]              start_chain;
  logic                    start;
  logic                    pending;
  logic [option_width-1:0] seq_option;
  logic [1:0]              word_addr;
  seq_state_e              state;

  // Option register and delayed start chain
  // Reset leaves stage 0 set so a boot sequence runs
  always_ff @(posedge clkin1_buffered or negedge arst_n) begin
    if (!arst_n) begin
      option_stored <= '0;
      start_chain   <= 8'h01;
    end else if (pll_option != option_stored) begin
      option_stored <= pll_option;
      // Restart delay on every change
      start_chain   <= 8'h01;
    end else begin
      start_chain <= {start_chain[6:0], 1'b0};
    end
  end

  // Start strobe from last stage
  assign start = start_chain[7];

  // Push whenever a word is ready and FIFO has room
  assign wr_en   = (state != seq_idle) && !full;
  assign wr_op   = (state == seq_done) ? drp_done : drp_write;
  assign wr_addr = word_addr;
  // Divider n is base shifted left by n
  assign wr_data = (state == seq_write) ? (option_base_div[seq_option] << word_addr) : '0;

  always_ff @(posedge clkin1_buffered or negedge arst_n) begin
    if (!arst_n) begin
      state      <= seq_idle;
      pending    <= 1'b0;
      seq_option <= '0;
      word_addr  <= '0;
    end else begin
      // Remember starts that land mid-sequence
      if (start && (state != seq_idle)) begin
        pending <= 1'b1;
      end
      case (state)
        seq_idle: begin
          if (start || pending) begin
            state      <= seq_write;
            // Latch option so one sequence stays consistent
            seq_option <= option_stored;
            word_addr  <= '0;
            pending    <= 1'b0;
          end
        end
        seq_write: begin
          if (wr_en) begin
            word_addr <= word_addr + 2'd1;
            // Last divider written
            if (word_addr == 2'd3) begin
              state <= seq_done;
            end
          end
        end
        seq_done: begin
          if (wr_en) begin
            state <= seq_idle;
          end
        end
        default: begin
          state <= seq_idle;
        end
      endcase
    end
  end

  // Stalled word stays on the bus until the FIFO takes it
  a_hold_when_full: assert property (
    @(posedge clkin1_buffered) disable iff (!arst_n)
    ((state != seq_idle) && full) |=>
      ($stable(wr_op) && $stable(wr_addr) && $stable(wr_data))
  );

endmodule

`default_nettype wire

// File: zxclk_pkg.sv
`default_nettype none

package zxclk_pkg;

  // Stored PLL option, one of eight speed profiles
  localparam int option_width = 3;

  // Divider value carried by each reconfiguration word
  localparam int div_width = 8;

  // Base divider per option
  // Output n divides by base, 2x base, 4x base, 8x base
  localparam logic [div_width-1:0] option_base_div [8] = '{
    8'd2,
    8'd3,
    8'd4,
    8'd5,
    8'd6,
    8'd7,
    8'd8,
    8'd9
  };

  // Reconfiguration command opcode
  // Write loads one divider, done closes the sequence and starts lock
  typedef enum logic [1:0] {
    drp_write = 2'd0,
    drp_done  = 2'd1
  } drp_op_e;

  // Sequencer FSM
  typedef enum logic [1:0] {
    seq_idle  = 2'd0,
    seq_write = 2'd1,
    seq_done  = 2'd2
  } seq_state_e;

endpackage

`default_nettype wire
